// ==== source/rc522Pkg.sv ====
package rc522Pkg;

    // register numbers, six bits as sent on the bus before the shift
    localparam logic [5:0] CommandReg    = 6'h01;  // starts and stops commands
    localparam logic [5:0] ComIrqReg     = 6'h04;  // interrupt request bits
    localparam logic [5:0] FIFODataReg   = 6'h09;  // 64 byte FIFO port
    localparam logic [5:0] FIFOLevelReg  = 6'h0A;  // FIFO fill level, bit 7 flushes
    localparam logic [5:0] BitFramingReg = 6'h0D;  // last byte bits and StartSend
    localparam logic [5:0] ModeReg       = 6'h11;  // general tx/rx modes, CRC preset
    localparam logic [5:0] TxModeReg     = 6'h12;  // tx data rate and framing
    localparam logic [5:0] RxModeReg     = 6'h13;  // rx data rate and framing
    localparam logic [5:0] TxControlReg  = 6'h14;  // antenna driver pins TX1/TX2
    localparam logic [5:0] TxASKReg      = 6'h15;  // modulation setting
    localparam logic [5:0] ModWidthReg   = 6'h24;  // modulation width
    localparam logic [5:0] TModeReg      = 6'h2A;  // internal timer mode
    localparam logic [5:0] TPrescalerReg = 6'h2B;  // timer prescaler low bits
    localparam logic [5:0] TReloadRegH   = 6'h2C;  // timer reload high byte
    localparam logic [5:0] TReloadRegL   = 6'h2D;  // timer reload low byte

    // commands written to CommandReg
    typedef enum logic [7:0] {
        Idle       = 8'h00,  // cancel the running command
        Transceive = 8'h0C   // send FIFO, then receive into it
    } pcdCmd;

    // commands sent to the card through the FIFO
    typedef enum logic [7:0] {
        Reqa   = 8'h26,  // request type A, 7 bit frame
        SelCl1 = 8'h93   // anticollision / select, cascade level 1
    } piccCmd;

    localparam int RX_IRQ_BIT    = 5;  // RxIRq in ComIrqReg
    localparam int SPI_READ_FLAG = 7;  // address byte MSB, 1 = read

    // four UID bytes plus BCC
    localparam logic [7:0] UID_FRAME_BYTES = 8'd5;

endpackage

// ==== source/readerPkg.sv ====
package readerPkg;

    typedef enum logic [3:0] {
        ChipReset,     // drive the chip reset low
        ResetWait,     // let the oscillator settle
        Init,          // fixed register table
        AntennaRead,   // fetch TxControlReg
        AntennaWrite,  // write it back with the drivers on
        Request,       // flush FIFO and send REQA
        IrqPoll,       // look for RxIRq
        Select,        // send SELECT CL1
        ReadLevel,     // FIFO level after SELECT
        ReadUid,       // four UID bytes
        ReadBcc,       // check byte
        Verdict,       // frame handed to the verdict block
        Hold           // settle step before the next poll
    } pollState;

    typedef logic [31:0] uidT;  // first received byte sits in [31:24]
    typedef logic [5:0]  ledT;  // {rgb1 B,G,R, rgb2 B,G,R}

    localparam ledT LED_ACCEPT = 6'b111000;
    localparam ledT LED_REJECT = 6'b000111;
    localparam ledT LED_OFF    = 6'b000000;

    localparam int RETRY_LIMIT = 6;  // ComIrqReg reads per REQA

    // defaults for a 100 MHz system clock
    localparam int DEF_STEP_CYCLES = 131072;    // about 1.3 ms per step
    localparam int DEF_RESET_STEPS = 48;        // chip recovery after hard reset
    localparam int DEF_HOLD_CYCLES = 50000000;  // half a second of LED
    localparam int DEF_SCLK_DIV    = 16;        // 3.125 MHz sclk

endpackage

// ==== source/spiMaster.sv ====
module spiMaster #(
    parameter int SCLK_DIV = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [5:0] adr,
    input  logic [7:0] datWr,
    output logic       ack,
    output logic [7:0] datRd,
    input  logic       miso,
    output logic       sclk,
    output logic       mosi,
    output logic       csN
);
    import rc522Pkg::*;

    localparam int DIV_W = $clog2(2 * SCLK_DIV);

    typedef enum logic [1:0] {
        SpiIdle,
        SpiSetup,  // csN low, first bit on mosi
        SpiShift,
        SpiHold    // csN back high, ack out
    } spiState;

    spiState        state;
    logic [DIV_W-1:0] divCnt;  // position inside one sclk period
    logic [3:0]     bitCnt;
    logic [15:0]    txShift;
    logic [7:0]     rxShift;
    logic [7:0]     addrByte;
    logic [15:0]    frame;
    logic           start;
    logic           riseEdge;
    logic           fallEdge;

    always_comb begin
        addrByte = {1'b0, adr, 1'b0};  // register number shifted left
        addrByte[SPI_READ_FLAG] = ~we;
        frame = {addrByte, (we ? datWr : 8'h00)};  // data byte is zero on reads
    end

    assign start    = (state == SpiIdle) && cyc && stb && !ack;  // ack cycle is not a new request
    assign riseEdge = (state == SpiShift) && (divCnt == DIV_W'(SCLK_DIV - 1));
    assign fallEdge = (state == SpiShift) && (divCnt == DIV_W'(2 * SCLK_DIV - 1));
    assign datRd    = rxShift;  // last eight sampled bits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= SpiIdle;
            divCnt <= '0;
            bitCnt <= '0;
            sclk   <= 1'b0;
            mosi   <= 1'b0;
            csN    <= 1'b1;
            ack    <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                SpiIdle: begin
                    if (start) begin
                        csN   <= 1'b0;
                        mosi  <= frame[15];  // mode 0, bit valid before first rise
                        state <= SpiSetup;
                    end
                end
                SpiSetup: begin
                    divCnt <= '0;
                    bitCnt <= '0;
                    state  <= SpiShift;
                end
                SpiShift: begin
                    divCnt <= divCnt + 1'b1;
                    if (riseEdge) begin
                        sclk <= 1'b1;
                    end
                    if (fallEdge) begin
                        sclk   <= 1'b0;
                        divCnt <= '0;
                        if (bitCnt == 4'd15) begin
                            state <= SpiHold;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                            mosi   <= txShift[14];  // next bit on the falling edge
                        end
                    end
                end
                SpiHold: begin
                    csN   <= 1'b1;
                    mosi  <= 1'b0;
                    ack   <= 1'b1;  // one cycle after the last fall
                    state <= SpiIdle;
                end
                default: state <= SpiIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            txShift <= frame;
        end else if (fallEdge) begin
            txShift <= {txShift[14:0], 1'b0};
        end
        if (riseEdge) begin
            rxShift <= {rxShift[6:0], miso};  // miso stable since the last fall
        end
    end

endmodule

// ==== source/cardPoller.sv ====
module cardPoller #(
    parameter int STEP_CYCLES = readerPkg::DEF_STEP_CYCLES,
    parameter int RESET_STEPS = readerPkg::DEF_RESET_STEPS
) (
    input  logic           clk,
    input  logic           rst_n,
    output logic           cyc,
    output logic           stb,
    output logic           we,
    output logic [5:0]     adr,
    output logic [7:0]     datWr,
    input  logic           ack,
    input  logic [7:0]     datRd,
    output logic           rstChip,
    output logic           frameDone,
    output readerPkg::uidT frameUid,
    output logic [7:0]     frameLevel,
    output logic [7:0]     frameBcc
);
    import rc522Pkg::*;
    import readerPkg::*;

    localparam int STEP_W  = $clog2(STEP_CYCLES);
    localparam int IDX_W   = $clog2(RESET_STEPS + 16);
    localparam int RETRY_W = $clog2(RETRY_LIMIT);

    pollState          state;
    pollState          nextPhase;  // phase after the last step of this one
    logic [STEP_W-1:0] stepCnt;
    logic              stepTick;
    logic [IDX_W-1:0]  idx;        // step inside the current phase
    logic [IDX_W-1:0]  lastIdx;
    logic [RETRY_W-1:0] retry;
    logic [7:0]        txCtl;      // TxControlReg with the drivers enabled
    logic              opBus;      // this step runs a bus cycle
    logic              opWe;
    logic [5:0]        opAdr;
    logic [7:0]        opDat;
    logic              issue;

    assign stepTick = (stepCnt == STEP_W'(STEP_CYCLES - 1));
    assign issue    = stepTick && !cyc && opBus;

    // what the current step sends
    always_comb begin
        opBus     = 1'b1;
        opWe      = 1'b1;
        opAdr     = CommandReg;
        opDat     = 8'h00;
        lastIdx   = '0;
        nextPhase = state;
        case (state)
            ChipReset: begin
                opBus     = 1'b0;
                nextPhase = ResetWait;
            end
            ResetWait: begin
                opBus     = 1'b0;
                lastIdx   = IDX_W'(RESET_STEPS - 1);
                nextPhase = Init;
            end
            Init: begin
                lastIdx   = IDX_W'(8);
                nextPhase = AntennaRead;
                case (idx)
                    0:       begin opAdr = TxModeReg;     opDat = 8'h00; end  // 106 kBd tx
                    1:       begin opAdr = RxModeReg;     opDat = 8'h00; end  // 106 kBd rx
                    2:       begin opAdr = ModWidthReg;   opDat = 8'h26; end
                    3:       begin opAdr = TModeReg;      opDat = 8'h80; end  // timer auto start
                    4:       begin opAdr = TPrescalerReg; opDat = 8'hA9; end
                    5:       begin opAdr = TReloadRegH;   opDat = 8'h03; end
                    6:       begin opAdr = TReloadRegL;   opDat = 8'hE8; end  // 25 ms timeout
                    7:       begin opAdr = TxASKReg;      opDat = 8'h40; end  // force 100% ASK
                    default: begin opAdr = ModeReg;       opDat = 8'h3D; end  // CRC preset 6363
                endcase
            end
            AntennaRead: begin
                opWe      = 1'b0;
                opAdr     = TxControlReg;
                nextPhase = AntennaWrite;
            end
            AntennaWrite: begin
                opAdr     = TxControlReg;
                opDat     = txCtl;
                nextPhase = Request;
            end
            Request: begin
                lastIdx   = IDX_W'(6);
                nextPhase = IrqPoll;
                case (idx)
                    0:       begin opAdr = CommandReg;    opDat = Idle;  end
                    1:       begin opAdr = ComIrqReg;     opDat = 8'h7F; end  // clear all irq bits
                    2:       begin opAdr = FIFOLevelReg;  opDat = 8'h80; end  // flush
                    3:       begin opAdr = FIFODataReg;   opDat = Reqa;  end
                    4:       begin opAdr = BitFramingReg; opDat = 8'h07; end  // 7 bit frame
                    5:       begin opAdr = CommandReg;    opDat = Transceive; end
                    default: begin opAdr = BitFramingReg; opDat = 8'h87; end  // StartSend
                endcase
            end
            IrqPoll: begin
                opWe  = 1'b0;
                opAdr = ComIrqReg;
            end
            Select: begin
                lastIdx   = IDX_W'(5);
                nextPhase = ReadLevel;
                case (idx)
                    0:       begin opAdr = FIFOLevelReg;  opDat = 8'h80;  end
                    1:       begin opAdr = FIFODataReg;   opDat = SelCl1; end
                    2:       begin opAdr = FIFODataReg;   opDat = 8'h20;  end  // NVB, no UID bits
                    3:       begin opAdr = BitFramingReg; opDat = 8'h00;  end
                    4:       begin opAdr = CommandReg;    opDat = Transceive; end
                    default: begin opAdr = BitFramingReg; opDat = 8'h80;  end
                endcase
            end
            ReadLevel: begin
                opWe      = 1'b0;
                opAdr     = FIFOLevelReg;
                nextPhase = ReadUid;
            end
            ReadUid: begin
                opWe      = 1'b0;
                opAdr     = FIFODataReg;
                lastIdx   = IDX_W'(3);
                nextPhase = ReadBcc;
            end
            ReadBcc: begin
                opWe      = 1'b0;
                opAdr     = FIFODataReg;
                nextPhase = Verdict;
            end
            Verdict: begin
                opBus     = 1'b0;
                nextPhase = Hold;
            end
            default: begin  // Hold
                opBus     = 1'b0;
                nextPhase = Request;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stepCnt   <= '0;
            state     <= ChipReset;
            idx       <= '0;
            retry     <= '0;
            cyc       <= 1'b0;
            stb       <= 1'b0;
            rstChip   <= 1'b1;
            frameDone <= 1'b0;
        end else begin
            stepCnt   <= stepTick ? '0 : stepCnt + 1'b1;
            frameDone <= 1'b0;
            if (ack) begin
                cyc <= 1'b0;
                stb <= 1'b0;
                if (state == IrqPoll) begin
                    retry <= retry + 1'b1;
                    if (datRd[RX_IRQ_BIT]) begin
                        state <= Select;  // card answered REQA
                        idx   <= '0;
                    end else if (retry == RETRY_W'(RETRY_LIMIT - 1)) begin
                        state <= Request;
                        idx   <= '0;
                    end
                end else if (idx != lastIdx) begin
                    idx <= idx + 1'b1;
                end else begin
                    idx       <= '0;
                    retry     <= '0;
                    state     <= nextPhase;
                    frameDone <= (state == ReadBcc);  // frame regs load on this edge
                end
            end else if (stepTick && !cyc) begin
                if (opBus) begin
                    cyc <= 1'b1;
                    stb <= 1'b1;
                end else begin
                    if (state == ChipReset) begin
                        rstChip <= 1'b0;
                    end else begin
                        rstChip <= 1'b1;  // low for exactly one step
                    end
                    if (idx != lastIdx) begin
                        idx <= idx + 1'b1;
                    end else begin
                        idx   <= '0;
                        state <= nextPhase;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            we    <= opWe;
            adr   <= opAdr;
            datWr <= opDat;
        end
        if (ack) begin
            case (state)
                AntennaRead: txCtl      <= datRd | 8'h03;  // TX1 and TX2 on
                ReadLevel:   frameLevel <= datRd;
                ReadUid:     frameUid   <= {frameUid[23:0], datRd};
                ReadBcc:     frameBcc   <= datRd;
                default:     ;
            endcase
        end
    end

endmodule

// ==== source/cardVerdict.sv ====
module cardVerdict #(
    parameter int             HOLD_CYCLES = readerPkg::DEF_HOLD_CYCLES,
    parameter readerPkg::uidT ACCEPT_UID  = 32'h2359A629,
    parameter readerPkg::uidT REJECT_UID  = 32'hF3F3A414
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           frameDone,
    input  readerPkg::uidT frameUid,
    input  logic [7:0]     frameLevel,
    input  logic [7:0]     frameBcc,
    output logic           cardOk,
    output readerPkg::uidT uid,
    output readerPkg::ledT led
);
    import rc522Pkg::*;
    import readerPkg::*;

    localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);

    logic [HOLD_W-1:0] holdCnt;
    logic              verified;
    ledT               pattern;

    assign verified = (frameLevel == UID_FRAME_BYTES) &&
                      (frameBcc == (frameUid[31:24] ^ frameUid[23:16] ^
                                    frameUid[15:8] ^ frameUid[7:0]));
    assign pattern  = (frameUid == ACCEPT_UID) ? LED_ACCEPT :
                      (frameUid == REJECT_UID) ? LED_REJECT : LED_OFF;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cardOk  <= 1'b0;
            uid     <= '0;
            led     <= LED_OFF;
            holdCnt <= '0;
        end else if (frameDone) begin
            uid <= frameUid;  // shown even when the check fails
            if (verified) begin
                cardOk  <= 1'b1;
                led     <= pattern;
                holdCnt <= HOLD_W'(HOLD_CYCLES - 1);  // restart the hold
            end
        end else if (cardOk) begin
            if (holdCnt == '0) begin
                cardOk <= 1'b0;
                led    <= LED_OFF;
            end else begin
                holdCnt <= holdCnt - 1'b1;
            end
        end
    end

endmodule

// ==== source/rfidReader.sv ====
module rfidReader #(
    parameter int             STEP_CYCLES = readerPkg::DEF_STEP_CYCLES,
    parameter int             RESET_STEPS = readerPkg::DEF_RESET_STEPS,
    parameter int             HOLD_CYCLES = readerPkg::DEF_HOLD_CYCLES,
    parameter int             SCLK_DIV    = readerPkg::DEF_SCLK_DIV,
    parameter readerPkg::uidT ACCEPT_UID  = 32'h2359A629,
    parameter readerPkg::uidT REJECT_UID  = 32'hF3F3A414
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           miso,
    output logic           sclk,
    output logic           mosi,
    output logic           csN,
    output logic           rstChip,
    output readerPkg::uidT uid,
    output logic           cardOk,
    output logic           rgb1B,
    output logic           rgb1G,
    output logic           rgb1R,
    output logic           rgb2B,
    output logic           rgb2G,
    output logic           rgb2R
);
    import readerPkg::*;

    logic       cyc;
    logic       stb;
    logic       we;
    logic       ack;
    logic [5:0] adr;
    logic [7:0] datWr;
    logic [7:0] datRd;
    logic       frameDone;
    uidT        frameUid;
    logic [7:0] frameLevel;
    logic [7:0] frameBcc;
    ledT        led;

    assign {rgb1B, rgb1G, rgb1R, rgb2B, rgb2G, rgb2R} = led;

    spiMaster #(
        .SCLK_DIV(SCLK_DIV)
    ) spi (
        .clk(clk), .rst_n(rst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr),
        .ack(ack), .datRd(datRd),
        .miso(miso), .sclk(sclk), .mosi(mosi), .csN(csN)
    );

    cardPoller #(
        .STEP_CYCLES(STEP_CYCLES),
        .RESET_STEPS(RESET_STEPS)
    ) poller (
        .clk(clk), .rst_n(rst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr),
        .ack(ack), .datRd(datRd),
        .rstChip(rstChip),
        .frameDone(frameDone), .frameUid(frameUid),
        .frameLevel(frameLevel), .frameBcc(frameBcc)
    );

    cardVerdict #(
        .HOLD_CYCLES(HOLD_CYCLES),
        .ACCEPT_UID(ACCEPT_UID),
        .REJECT_UID(REJECT_UID)
    ) verdict (
        .clk(clk), .rst_n(rst_n),
        .frameDone(frameDone), .frameUid(frameUid),
        .frameLevel(frameLevel), .frameBcc(frameBcc),
        .cardOk(cardOk), .uid(uid), .led(led)
    );

endmodule

// ==== verif/rc522Model.sv ====
module rc522Model #(
    parameter int STEP_NS = 2560
) (
    input  logic           sclk,
    input  logic           mosi,
    input  logic           csN,
    input  logic           rstChip,
    output logic           miso,
    input  readerPkg::uidT cardUid,
    input  logic           cardPresent,
    input  logic           bccErr,
    input  logic [7:0]     fifoLevel,
    output int             errCount,
    output int             bccReads,
    output int             reqaCount,
    output int             rstPulses
);
    timeunit 1ns;
    timeprecision 100ps;
    import rc522Pkg::*;
    import readerPkg::*;

    localparam logic [7:0] TXCTL_RESET = 8'h80;  // chip reset value of TxControlReg
    localparam int         INIT_FRAMES = 11;     // table, antenna read, antenna write

    logic [15:0] rxFrame;
    logic [7:0]  rdData;
    int          bitCnt;
    int          frameIdx;  // frames since the last hard reset
    int          fifoIdx;
    int          irqReads;  // ComIrqReg reads since the last REQA
    bit          inFrame;
    bit          answered;  // RxIRq returned since the last REQA
    bit          reqaSeen;
    time         rstFall;

    initial begin
        miso      = 1'b0;
        errCount  = 0;
        bccReads  = 0;
        reqaCount = 0;
        rstPulses = 0;
    end

    task automatic valueError(input string name, input logic [15:0] exp, input logic [15:0] got);
        $display("ERR %0t %s exp %0h got %0h", $time, name, exp, got);
        errCount++;
    endtask

    // expected {we, adr, data} of the frames after a hard reset
    function automatic logic [14:0] initFrame(input int n);
        case (n)
            0:       return {1'b1, TxModeReg, 8'h00};
            1:       return {1'b1, RxModeReg, 8'h00};
            2:       return {1'b1, ModWidthReg, 8'h26};
            3:       return {1'b1, TModeReg, 8'h80};
            4:       return {1'b1, TPrescalerReg, 8'hA9};
            5:       return {1'b1, TReloadRegH, 8'h03};
            6:       return {1'b1, TReloadRegL, 8'hE8};
            7:       return {1'b1, TxASKReg, 8'h40};
            8:       return {1'b1, ModeReg, 8'h3D};
            9:       return {1'b0, TxControlReg, 8'h00};
            default: return {1'b1, TxControlReg, TXCTL_RESET | 8'h03};  // antenna drivers on
        endcase
    endfunction

    function automatic logic [7:0] readValue(input logic [5:0] r);
        logic [7:0] bcc;
        bcc = cardUid[31:24] ^ cardUid[23:16] ^ cardUid[15:8] ^ cardUid[7:0];
        if (bccErr) begin
            bcc = bcc ^ 8'h5A;  // corrupt the check byte
        end
        case (r)
            ComIrqReg:    return cardPresent ? 8'(1 << RX_IRQ_BIT) : 8'h00;
            TxControlReg: return TXCTL_RESET;
            FIFOLevelReg: return fifoLevel;
            FIFODataReg:  return (fifoIdx < 4) ? cardUid[31 - 8 * fifoIdx -: 8] : bcc;
            default:      return 8'h00;
        endcase
    endfunction

    task automatic handleFrame(input logic we, input logic [5:0] r, input logic [7:0] d);
        if (frameIdx < INIT_FRAMES) begin
            assert ({we, r, d} === initFrame(frameIdx))
                else valueError("init frame {we,adr,dat}", initFrame(frameIdx), {we, r, d});
        end
        frameIdx++;
        if (!we) begin
            assert (d === 8'h00) else valueError("mosi data byte on read", 8'h00, d);
        end
        if (we && r == FIFOLevelReg && d[7]) begin
            fifoIdx = 0;  // flush
        end
        if (!we && r == FIFODataReg) begin
            if (fifoIdx == 4) begin
                bccReads++;
            end
            fifoIdx++;
        end
        if (!we && r == ComIrqReg) begin
            irqReads++;
            answered = answered | cardPresent;
        end
        if (we && r == FIFODataReg && d == Reqa) begin
            if (reqaSeen && !answered) begin
                assert (irqReads == RETRY_LIMIT)
                    else valueError("ComIrqReg reads per REQA", RETRY_LIMIT, irqReads);
            end
            reqaSeen = 1'b1;
            answered = 1'b0;
            irqReads = 0;
            reqaCount++;
        end
        if (we && r == FIFODataReg && d == SelCl1) begin
            assert (cardPresent) else begin
                $display("%0t SELECT was sent with no card in the field", $time);
                errCount++;
            end
        end
    endtask

    always @(negedge rstChip) begin  // hard reset clears the chip
        rstPulses++;
        rstFall  = $time;
        frameIdx = 0;
        fifoIdx  = 0;
        irqReads = 0;
        answered = 1'b0;
        reqaSeen = 1'b0;
    end

    always @(posedge rstChip) begin
        if (rstPulses > 0) begin
            assert ($time - rstFall == STEP_NS) else begin
                $display("ERR %0t rstChip low ns exp %0d got %0d", $time, STEP_NS,
                         $time - rstFall);
                errCount++;
            end
        end
    end

    always @(negedge csN) begin
        assert (sclk === 1'b0) else valueError("sclk at csN fall", 1'b0, sclk);  // mode 0 idle
        inFrame = 1'b1;
        bitCnt  = 0;
        rxFrame = '0;
    end

    always @(posedge sclk) begin
        assert (csN === 1'b0) else begin
            $display("%0t sclk rose while csN was high", $time);
            errCount++;
        end
        if (inFrame) begin
            rxFrame = {rxFrame[14:0], mosi};
            bitCnt++;
        end
    end

    always @(negedge sclk) begin
        if (inFrame && bitCnt == 8) begin
            rdData = readValue(rxFrame[6:1]);  // address byte is complete
        end
        if (inFrame && bitCnt >= 8 && bitCnt < 16) begin
            miso = rdData[15 - bitCnt];  // shift out on the falling edge
        end
    end

    always @(posedge csN) begin
        if (inFrame) begin
            inFrame = 1'b0;
            miso    = 1'b0;
            assert (bitCnt == 16) else valueError("sclk rises per frame", 16, bitCnt);
            assert (sclk === 1'b0) else valueError("sclk at csN rise", 1'b0, sclk);
            assert (rxFrame[8] === 1'b0) else valueError("address byte bit 0", 1'b0, rxFrame[8]);
            handleFrame(!rxFrame[15], rxFrame[14:9], rxFrame[7:0]);
        end
    end

endmodule

// ==== verif/rfidReaderTb.sv ====
module rfidReaderTb;
    timeunit 1ns;
    timeprecision 100ps;
    import readerPkg::*;

    localparam int  STEP_CYCLES = 64;
    localparam int  RESET_STEPS = 4;
    localparam int  HOLD_CYCLES = 2000;
    localparam int  SCLK_DIV    = 2;
    localparam uidT ACCEPT_UID  = 32'h2359A629;
    localparam uidT REJECT_UID  = 32'hF3F3A414;
    localparam int  NUM_TESTS   = 6;
    localparam int  MAX_CYCLES  = NUM_TESTS * 120 * STEP_CYCLES;  // 120 steps per scenario

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       miso;
    logic       sclk;
    logic       mosi;
    logic       csN;
    logic       rstChip;
    logic       cardOk;
    logic       rgb1B;
    logic       rgb1G;
    logic       rgb1R;
    logic       rgb2B;
    logic       rgb2G;
    logic       rgb2R;
    uidT        uid;
    ledT        led;
    uidT        cardUid = '0;  // card in the field, set per scenario
    uidT        unknownUid;
    logic       cardPresent = 1'b0;
    logic       bccErr = 1'b0;
    logic [7:0] fifoLevel = 8'd5;
    int         errCount;
    int         bccReads;
    int         reqaCount;
    int         rstPulses;
    int         tbErrors = 0;
    int         failedTests = 0;
    int         cycles = 0;
    int         seed = 8;
    int         order[NUM_TESTS];

    assign led = {rgb1B, rgb1G, rgb1R, rgb2B, rgb2G, rgb2R};

    rfidReader #(
        .STEP_CYCLES(STEP_CYCLES), .RESET_STEPS(RESET_STEPS),
        .HOLD_CYCLES(HOLD_CYCLES), .SCLK_DIV(SCLK_DIV),
        .ACCEPT_UID(ACCEPT_UID), .REJECT_UID(REJECT_UID)
    ) UUT (
        .clk(clk), .rst_n(rst_n), .miso(miso),
        .sclk(sclk), .mosi(mosi), .csN(csN), .rstChip(rstChip),
        .uid(uid), .cardOk(cardOk),
        .rgb1B(rgb1B), .rgb1G(rgb1G), .rgb1R(rgb1R),
        .rgb2B(rgb2B), .rgb2G(rgb2G), .rgb2R(rgb2R)
    );

    rc522Model #(
        .STEP_NS(STEP_CYCLES * 40)
    ) chip (
        .sclk(sclk), .mosi(mosi), .csN(csN), .rstChip(rstChip), .miso(miso),
        .cardUid(cardUid), .cardPresent(cardPresent), .bccErr(bccErr), .fifoLevel(fifoLevel),
        .errCount(errCount), .bccReads(bccReads), .reqaCount(reqaCount), .rstPulses(rstPulses)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: no result after %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERR %0t %s exp %0h got %0h", $time, name, exp, got);
            tbErrors++;
        end
    endtask

    task automatic nextSample();
        @(posedge clk);
        #2;  // outputs settled
    endtask

    // reset only while csN is high so no frame gets cut
    task automatic resetDut();
        nextSample();
        while (csN !== 1'b1) begin
            nextSample();
        end
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;
    endtask

    task automatic runTest(input int n, input int kind);
        string name;
        int    errsBefore;
        int    pulsesBefore;
        int    startCount;
        int    held;
        logic  expOk;
        ledT   expLed;
        errsBefore   = tbErrors + errCount;
        pulsesBefore = rstPulses;
        resetDut();
        cardPresent = (kind != 0);
        bccErr      = (kind == 4);
        fifoLevel   = (kind == 5) ? 8'd4 : 8'd5;
        case (kind)
            0: begin
                name    = "no card";
                cardUid = '0;
                expOk   = 0;
                expLed  = LED_OFF;
            end
            1: begin
                name    = "accepted card";
                cardUid = ACCEPT_UID;
                expOk   = 1;
                expLed  = LED_ACCEPT;
            end
            2: begin
                name    = "rejected card";
                cardUid = REJECT_UID;
                expOk   = 1;
                expLed  = LED_REJECT;
            end
            3: begin
                name    = "unknown card";
                cardUid = unknownUid;
                expOk   = 1;
                expLed  = LED_OFF;
            end
            4: begin
                name    = "wrong BCC";
                cardUid = ACCEPT_UID;
                expOk   = 0;
                expLed  = LED_OFF;
            end
            default: begin
                name    = "short FIFO";
                cardUid = REJECT_UID;
                expOk   = 0;
                expLed  = LED_OFF;
            end
        endcase
        if (kind == 0) begin
            startCount = reqaCount;
            while (reqaCount < startCount + 3) begin  // model checks the retry spacing
                nextSample();
            end
            checkValue("uid", 32'h0, uid);
        end else begin
            startCount = bccReads;
            while (bccReads == startCount) begin
                nextSample();
            end
            repeat (2) nextSample();  // ack -> frameDone -> outputs
            checkValue("uid", cardUid, uid);
        end
        checkValue("cardOk", expOk, cardOk);
        checkValue("led", expLed, led);
        if (expOk) begin
            held = 1;
            while (cardOk === 1'b1) begin
                nextSample();
                if (cardOk === 1'b1) begin
                    held++;
                end
            end
            checkValue("cardOk high cycles", HOLD_CYCLES, held);
            checkValue("led after hold", LED_OFF, led);
        end
        checkValue("rstChip pulses", pulsesBefore + 1, rstPulses);
        if (tbErrors + errCount == errsBefore) begin
            $display("test %0d %s: ok", n, name);
        end else begin
            $display("test %0d %s: failed", n, name);
            failedTests++;
        end
    endtask

    initial begin
        int j;
        int tmp;
        unknownUid = $random(seed);
        if (unknownUid == ACCEPT_UID || unknownUid == REJECT_UID) begin
            unknownUid = ~unknownUid;
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            order[i] = i;
        end
        for (int i = NUM_TESTS - 1; i > 0; i--) begin  // shuffle the scenario order
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            runTest(i, order[i]);
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failedTests,
                 tbErrors + errCount);
        if (failedTests == 0 && tbErrors + errCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/rc522Pkg.sv
source/readerPkg.sv
source/spiMaster.sv
source/cardPoller.sv
source/cardVerdict.sv
source/rfidReader.sv
verif/rc522Model.sv
verif/rfidReaderTb.sv

// ==== Bender.yml ====
package:
  name: rfid_reader

sources:
  - source/rc522Pkg.sv
  - source/readerPkg.sv
  - source/spiMaster.sv
  - source/cardPoller.sv
  - source/cardVerdict.sv
  - source/rfidReader.sv
  - target: simulation
    files:
      - verif/rc522Model.sv
      - verif/rfidReaderTb.sv
